/* test/mips_patterns.txt */
// instruction _ flags {reg_write,mem_write,branch_taken} _ dest _ result _ store_data
// pc of each word is 4 times its line position; registers start at zero
20010005_4_01_00000005_00000000
2002FFFD_4_02_FFFFFFFD_00000000
00221820_4_03_00000002_FFFFFFFD
00222022_4_04_00000008_FFFFFFFD
00642824_4_05_00000000_00000008
00243025_4_06_0000000D_00000008
0041382A_4_07_00000001_00000005
0022402A_4_08_00000000_FFFFFFFD
20200007_0_00_0000000C_00000000
00014820_4_09_00000005_00000005
00210020_0_00_0000000A_00000005
00005025_4_0A_00000000_00000000
10290003_1_09_00000040_00000005
1022FFFE_0_02_00000030_FFFFFFFD
AC24000C_2_04_00000011_00000008
206BFFFF_4_0B_00000001_00000000
AD6BFFFC_2_0B_FFFFFFFD_00000001
01646022_4_0C_FFFFFFF9_00000008
0180682A_4_0D_00000001_00000000
01AC7020_4_0E_FFFFFFFA_FFFFFFF9
10000000_1_00_00000054_00000000

/* sources.f */
src/mips_pkg.sv
src/fetch_wb_slave.sv
src/register_file.sv
src/decode_stage.sv
src/pipe_reg.sv
src/execute_stage.sv
src/mips_core.sv
test/mips_core_chk.sv
test/mips_core_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --top-module mips_core_tb -f sources.f -o sim
./obj_dir/sim > sim.log 2>&1 || true
cat sim.log
if grep -q "TB FAILED" sim.log; then
  exit 1
fi
exit 0

/* test/mips_core_tb.sv */
// Testbench for mips_core; sends Wishbone words from the pattern file and checks each retire
`default_nettype none

module mips_core_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import mips_pkg::*;

  localparam int MAX_ENTRIES   = 64;
  localparam int ACK_TIMEOUT   = 200;
  localparam int DRAIN_TIMEOUT = 2000;
  localparam int DRAIN_CYCLES  = 20;

  logic                clk;
  logic                reset;
  logic                wb_cyc;
  logic                wb_stb;
  logic                wb_we;
  logic [XLEN-1:0]     wb_dat_w;
  logic                wb_ack;
  logic                retire_ready;
  logic                retire_valid;
  retire_t             retire;

  // Each entry holds instruction, flags {reg_write, mem_write, branch_taken}, dest, result, store
  logic [107:0]        patterns [0:MAX_ENTRIES-1];
  int                  num_entries;
  int                  retired_count;
  int                  mismatch_count;
  int                  other_errors;

  mips_core dut (
    .clk          (clk),
    .reset        (reset),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_we        (wb_we),
    .wb_dat_w     (wb_dat_w),
    .wb_ack       (wb_ack),
    .retire_ready (retire_ready),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // Random back-pressure with ready about three cycles in four
  initial begin
    void'($urandom(32'haa8b));
    retire_ready = 1'b0;
    forever begin
      @(posedge clk);
      if (reset) begin
        retire_ready <= 1'b0;
      end else begin
        retire_ready <= ($urandom % 4) != 0;
      end
    end
  end

  task automatic compare_field(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (expected !== actual) begin
      mismatch_count++;
      $display("mismatch at %0t: %s expected %h got %h", $time, name, expected, actual);
    end
  endtask

  task automatic check_retire();
    logic [107:0] entry;
    if (retired_count >= num_entries) begin
      other_errors++;
      $display("unexpected extra retire at %0t", $time);
    end else begin
      entry = patterns[retired_count];
      compare_field("retire.reg_write", {31'd0, entry[74]}, {31'd0, retire.reg_write});
      compare_field("retire.mem_write", {31'd0, entry[73]}, {31'd0, retire.mem_write});
      compare_field("retire.branch_taken", {31'd0, entry[72]},
                    {31'd0, retire.branch_taken});
      compare_field("retire.dest", {27'd0, entry[68:64]}, {27'd0, retire.dest});
      compare_field("retire.result", entry[63:32], retire.result);
      compare_field("retire.store_data", entry[31:0], retire.store_data);
    end
    retired_count++;
  endtask

  // Sampled on the falling edge while retire and ready are settled
  always @(negedge clk) begin
    if (!reset && retire_valid && retire_ready) begin
      check_retire();
    end
  end

  task automatic send_word(input int index, input logic [31:0] word);
    int   cycles;
    logic acked;
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= 1'b1;
    wb_dat_w <= word;
    acked  = 1'b0;
    cycles = 0;
    while (!acked && cycles < ACK_TIMEOUT) begin
      @(negedge clk);
      if (wb_ack) begin
        acked = 1'b1;
      end
      cycles++;
    end
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
    if (!acked) begin
      other_errors++;
      $display("timeout waiting for wb_ack on word %0d", index);
    end
  endtask

  task automatic wait_for_retires();
    int cycles;
    cycles = 0;
    while (retired_count < num_entries && cycles < DRAIN_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (retired_count < num_entries) begin
      other_errors++;
      $display("timeout waiting for retires, got %0d of %0d", retired_count, num_entries);
    end
  endtask

  initial begin
    reset          = 1'b1;
    wb_cyc         = 1'b0;
    wb_stb         = 1'b0;
    wb_we          = 1'b0;
    wb_dat_w       = '0;
    retired_count  = 0;
    mismatch_count = 0;
    other_errors   = 0;
    num_entries    = 0;
    for (int i = 0; i < MAX_ENTRIES; i++) begin
      patterns[i] = '1;
    end
    $readmemh("test/mips_patterns.txt", patterns);
    while (num_entries < MAX_ENTRIES && patterns[num_entries] !== '1) begin
      num_entries++;
    end
    if (num_entries == 0) begin
      other_errors++;
      $display("no entries read from the pattern file");
    end

    repeat (10) @(posedge clk);
    reset <= 1'b0;

    for (int i = 0; i < num_entries && other_errors == 0; i++) begin
      send_word(i, patterns[i][107:76]);
    end
    wait_for_retires();
    // Extra time so a duplicated retire would show up
    repeat (DRAIN_CYCLES) @(posedge clk);

    $display("errors: mismatches=%0d other=%0d retired=%0d of %0d",
             mismatch_count, other_errors, retired_count, num_entries);
    if (mismatch_count == 0 && other_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* test/mips_core_chk.sv */
// Concurrent protocol assertions bound to every mips_core instance
`default_nettype none

module mips_core_chk (
  input wire logic              clk,
  input wire logic              reset,
  input wire logic              wb_cyc,
  input wire logic              wb_stb,
  input wire logic              wb_ack,
  input wire logic              retire_ready,
  input wire logic              retire_valid,
  input wire mips_pkg::retire_t retire
);
  timeunit 1ns;
  timeprecision 1ps;

  ack_in_cycle: assert property (@(posedge clk) disable iff (reset)
    wb_ack |-> (wb_cyc && wb_stb))
    else $error("wb_ack without wb_cyc and wb_stb");

  // Single-cycle ack pulse
  ack_single: assert property (@(posedge clk) disable iff (reset)
    wb_ack |=> !wb_ack)
    else $error("wb_ack high for two cycles");

  retire_held: assert property (@(posedge clk) disable iff (reset)
    (retire_valid && !retire_ready) |=> $stable(retire))
    else $error("retire changed while held");

  // Reset is synchronous, so the valid is cleared from the edge after reset is seen
  reset_quiet: assert property (@(posedge clk) reset |=> !retire_valid)
    else $error("retire_valid high during reset");

endmodule

bind mips_core mips_core_chk chk (.*);

`default_nettype wire

/* src/mips_core.sv */
// Top level of the decode-to-execute MIPS slice; Wishbone instruction input, retire output
`default_nettype none

module mips_core (
  input  logic                      clk,
  input  logic                      reset,
  // Wishbone classic instruction port, write only
  input  logic                      wb_cyc,
  input  logic                      wb_stb,
  input  logic                      wb_we,
  input  logic [mips_pkg::XLEN-1:0] wb_dat_w,
  output logic                      wb_ack,
  // Retire port
  input  logic                      retire_ready,
  output logic                      retire_valid,
  output mips_pkg::retire_t         retire
);
  import mips_pkg::*;

  logic  advance;
  logic  ifid_valid;
  ifid_t ifid;
  logic  id_valid;
  idex_t id_payload;
  logic  ex_valid;
  idex_t ex_payload;
  wb_t   wb;

  fetch_wb_slave u_fetch (
    .clk        (clk),
    .reset      (reset),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_dat_w   (wb_dat_w),
    .wb_ack     (wb_ack),
    .advance    (advance),
    .ifid_valid (ifid_valid),
    .ifid       (ifid)
  );

  decode_stage u_decode (
    .clk        (clk),
    .reset      (reset),
    .ifid_valid (ifid_valid),
    .ifid       (ifid),
    .wb         (wb),
    .idex_valid (id_valid),
    .idex       (id_payload)
  );

  // ID/EX latch
  pipe_reg #(.payload_t(idex_t)) id_ex (
    .clk       (clk),
    .reset     (reset),
    .en        (advance),
    .in_valid  (id_valid),
    .in        (id_payload),
    .out_valid (ex_valid),
    .out       (ex_payload)
  );

  execute_stage u_execute (
    .clk          (clk),
    .reset        (reset),
    .idex_valid   (ex_valid),
    .idex         (ex_payload),
    .retire_ready (retire_ready),
    .retire_valid (retire_valid),
    .retire       (retire),
    .wb           (wb),
    .advance      (advance)
  );

endmodule

`default_nettype wire

/* src/execute_stage.sv */
// Execute stage with ALU and forwarding, branch target, EX/MEM latch and retire handshake
`default_nettype none

module execute_stage (
  input  logic              clk,
  input  logic              reset,
  input  logic              idex_valid,
  input  mips_pkg::idex_t   idex,
  input  logic              retire_ready,
  output logic              retire_valid,
  output mips_pkg::retire_t retire,
  output mips_pkg::wb_t     wb,
  output logic              advance
);
  import mips_pkg::*;

  logic [2:0]      alu_fn;
  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] alu_b;
  logic [XLEN-1:0] alu_y;
  logic            fwd_a;
  logic            fwd_b;
  retire_t         ex_out;

  always_comb begin
    case (idex.ctrl.alu_op)
      ALU_OP_ADD: alu_fn = ALU_FN_ADD;
      ALU_OP_SUB: alu_fn = ALU_FN_SUB;
      ALU_OP_FUNCT: begin
        case (idex.funct)
          FN_SUB:  alu_fn = ALU_FN_SUB;
          FN_AND:  alu_fn = ALU_FN_AND;
          FN_OR:   alu_fn = ALU_FN_OR;
          FN_SLT:  alu_fn = ALU_FN_SLT;
          default: alu_fn = ALU_FN_ADD;
        endcase
      end
      default: alu_fn = ALU_FN_ADD;
    endcase
  end

  // Forward from the instruction waiting in EX/MEM before it writes back
  assign fwd_a = retire_valid && retire.reg_write && retire.dest != 5'd0 &&
                 retire.dest == idex.rs;
  assign fwd_b = retire_valid && retire.reg_write && retire.dest != 5'd0 &&
                 retire.dest == idex.rt;
  assign op_a  = fwd_a ? retire.result : idex.read_data_1;
  assign op_b  = fwd_b ? retire.result : idex.read_data_2;
  assign alu_b = idex.ctrl.alu_src ? idex.sign_extended_imm : op_b;

  always_comb begin
    case (alu_fn)
      ALU_FN_SUB: alu_y = op_a - alu_b;
      ALU_FN_AND: alu_y = op_a & alu_b;
      ALU_FN_OR:  alu_y = op_a | alu_b;
      ALU_FN_SLT: alu_y = XLEN'($signed(op_a) < $signed(alu_b));
      default:    alu_y = op_a + alu_b;
    endcase
  end

  always_comb begin
    ex_out.reg_write    = idex.ctrl.reg_write;
    ex_out.mem_write    = idex.ctrl.mem_write;
    // Zero test on the subtract result
    ex_out.branch_taken = idex.ctrl.branch && alu_y == '0;
    ex_out.dest         = idex.ctrl.reg_dst ? idex.rd : idex.rt;
    ex_out.result       = idex.ctrl.branch ?
                          idex.next_pc + (idex.sign_extended_imm << 2) : alu_y;
    ex_out.store_data   = op_b;
  end

  // Whole pipeline moves when the latch is empty or retiring
  assign advance = !retire_valid || retire_ready;

  pipe_reg #(.payload_t(retire_t)) ex_mem (
    .clk       (clk),
    .reset     (reset),
    .en        (advance),
    .in_valid  (idex_valid),
    .in        (ex_out),
    .out_valid (retire_valid),
    .out       (retire)
  );

  assign wb.en   = retire_valid && retire_ready && retire.reg_write;
  assign wb.addr = retire.dest;
  assign wb.data = retire.result;

endmodule

`default_nettype wire

/* src/pipe_reg.sv */
// Pipeline latch for any payload type, with valid, load enable and clear on reset
`default_nettype none

module pipe_reg #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     en,
  input  logic     in_valid,
  input  payload_t in,
  output logic     out_valid,
  output payload_t out
);

  // Holds its contents while en is low
  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
      out       <= '0;
    end else if (en) begin
      out_valid <= in_valid;
      out       <= in;
    end
  end

endmodule

`default_nettype wire

/* src/decode_stage.sv */
// Instruction decode with main control, sign extension and register reads for the ID/EX payload
`default_nettype none

module decode_stage (
  input  logic            clk,
  input  logic            reset,
  input  logic            ifid_valid,
  input  mips_pkg::ifid_t ifid,
  input  mips_pkg::wb_t   wb,
  output logic            idex_valid,
  output mips_pkg::idex_t idex
);
  import mips_pkg::*;

  logic [5:0]      opcode;
  logic [4:0]      rs;
  logic [4:0]      rt;
  logic [4:0]      rd;
  logic [15:0]     imm;
  logic [XLEN-1:0] rs_data;
  logic [XLEN-1:0] rt_data;
  ctrl_t           ctrl;
  logic [4:0]      dest;

  // Instruction fields
  assign opcode = ifid.instruction[31:26];
  assign rs     = ifid.instruction[25:21];
  assign rt     = ifid.instruction[20:16];
  assign rd     = ifid.instruction[15:11];
  assign imm    = ifid.instruction[15:0];

  register_file u_register_file (
    .clk     (clk),
    .reset   (reset),
    .rs_addr (rs),
    .rt_addr (rt),
    .rs_data (rs_data),
    .rt_data (rt_data),
    .wb      (wb)
  );

  always_comb begin
    ctrl = '0;
    case (opcode)
      OP_RTYPE: begin
        ctrl.reg_dst   = 1'b1;
        ctrl.alu_op    = ALU_OP_FUNCT;
        ctrl.reg_write = 1'b1;
      end
      OP_ADDI: begin
        ctrl.alu_src   = 1'b1;
        ctrl.alu_op    = ALU_OP_ADD;
        ctrl.reg_write = 1'b1;
      end
      OP_BEQ: begin
        ctrl.alu_op = ALU_OP_SUB;
        ctrl.branch = 1'b1;
      end
      OP_SW: begin
        ctrl.alu_src   = 1'b1;
        ctrl.alu_op    = ALU_OP_ADD;
        ctrl.mem_write = 1'b1;
      end
      default: ctrl = '0;
    endcase
    // A write to register zero is dropped here so later stages never see one
    dest = ctrl.reg_dst ? rd : rt;
    if (dest == 5'd0) begin
      ctrl.reg_write = 1'b0;
    end
  end

  always_comb begin
    idex.read_data_1       = rs_data;
    idex.read_data_2       = rt_data;
    idex.sign_extended_imm = {{(XLEN-16){imm[15]}}, imm};
    idex.rs                = rs;
    idex.rt                = rt;
    idex.rd                = rd;
    idex.next_pc           = ifid.pc + XLEN'(4);
    idex.funct             = ifid.instruction[5:0];
    idex.ctrl              = ctrl;
  end

  assign idex_valid = ifid_valid;

endmodule

`default_nettype wire

/* src/register_file.sv */
// Integer register file with two read ports, one write port and write-through bypass
`default_nettype none

module register_file (
  input  logic                      clk,
  input  logic                      reset,
  input  logic [4:0]                rs_addr,
  input  logic [4:0]                rt_addr,
  output logic [mips_pkg::XLEN-1:0] rs_data,
  output logic [mips_pkg::XLEN-1:0] rt_data,
  input  mips_pkg::wb_t             wb
);
  import mips_pkg::*;

  // Register zero is not stored
  logic [XLEN-1:0] regs [1:NREG-1];

  function automatic logic [XLEN-1:0] read_port(input logic [4:0] addr);
    if (addr == 5'd0) begin
      return '0;
    end else if (wb.en && wb.addr == addr) begin
      return wb.data;
    end
    return regs[addr];
  endfunction

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < NREG; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.en && wb.addr != 5'd0) begin
      regs[wb.addr] <= wb.data;
    end
  end

  // Re-evaluated on any change of the registers or the write-back bus
  always_comb begin
    rs_data = read_port(rs_addr);
    rt_data = read_port(rt_addr);
  end

endmodule

`default_nettype wire

/* src/fetch_wb_slave.sv */
// Wishbone classic write slave that takes instruction words and holds the IF/ID latch
`default_nettype none

module fetch_wb_slave (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     wb_cyc,
  input  logic                     wb_stb,
  input  logic                     wb_we,
  input  logic [mips_pkg::XLEN-1:0] wb_dat_w,
  output logic                     wb_ack,
  input  logic                     advance,
  output logic                     ifid_valid,
  output mips_pkg::ifid_t          ifid
);
  import mips_pkg::*;

  logic [XLEN-1:0] pc;
  logic            accept;

  // One word per request; ack low in the previous cycle keeps it a single pulse
  assign accept = wb_cyc && wb_stb && wb_we && advance && !wb_ack;

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_ack     <= 1'b0;
      pc         <= '0;
      ifid_valid <= 1'b0;
      ifid       <= '0;
    end else begin
      wb_ack <= accept;
      if (accept) begin
        pc <= pc + XLEN'(4);
      end
      // Latch moves only with the rest of the pipeline
      if (advance) begin
        ifid_valid <= accept;
        if (accept) begin
          ifid.instruction <= wb_dat_w;
          ifid.pc          <= pc;
        end else begin
          ifid <= '0;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* src/mips_pkg.sv */
// Shared widths, MIPS opcode and function codes, and the stage payload structs
`default_nettype none

package mips_pkg;

  localparam int XLEN = 32;
  localparam int NREG = 32;

  // Primary opcodes, instruction bits 31:26
  localparam logic [5:0] OP_RTYPE = 6'h00;
  localparam logic [5:0] OP_BEQ   = 6'h04;
  localparam logic [5:0] OP_ADDI  = 6'h08;
  localparam logic [5:0] OP_SW    = 6'h2b;

  // R-type function field, bits 5:0
  localparam logic [5:0] FN_ADD = 6'h20;
  localparam logic [5:0] FN_SUB = 6'h22;
  localparam logic [5:0] FN_AND = 6'h24;
  localparam logic [5:0] FN_OR  = 6'h25;
  localparam logic [5:0] FN_SLT = 6'h2a;

  // Main control to ALU control
  localparam logic [1:0] ALU_OP_ADD   = 2'b00;
  localparam logic [1:0] ALU_OP_SUB   = 2'b01;
  localparam logic [1:0] ALU_OP_FUNCT = 2'b10;

  // ALU function select inside the execute stage
  localparam logic [2:0] ALU_FN_ADD = 3'd0;
  localparam logic [2:0] ALU_FN_SUB = 3'd1;
  localparam logic [2:0] ALU_FN_AND = 3'd2;
  localparam logic [2:0] ALU_FN_OR  = 3'd3;
  localparam logic [2:0] ALU_FN_SLT = 3'd4;

  typedef struct packed {
    logic       alu_src;
    logic [1:0] alu_op;
    logic       reg_dst;
    logic       reg_write;
    logic       mem_write;
    logic       branch;
  } ctrl_t;

  typedef struct packed {
    logic [XLEN-1:0] instruction;
    logic [XLEN-1:0] pc;
  } ifid_t;

  typedef struct packed {
    logic [XLEN-1:0] read_data_1;
    logic [XLEN-1:0] read_data_2;
    logic [XLEN-1:0] sign_extended_imm;
    logic [4:0]      rs;
    logic [4:0]      rt;
    logic [4:0]      rd;
    logic [XLEN-1:0] next_pc;
    logic [5:0]      funct;
    ctrl_t           ctrl;
  } idex_t;

  // Also the retire port; result is the branch target for beq, the address for sw
  typedef struct packed {
    logic            reg_write;
    logic            mem_write;
    logic            branch_taken;
    logic [4:0]      dest;
    logic [XLEN-1:0] result;
    logic [XLEN-1:0] store_data;
  } retire_t;

  typedef struct packed {
    logic            en;
    logic [4:0]      addr;
    logic [XLEN-1:0] data;
  } wb_t;

endpackage

`default_nettype wire
